// ==== vlog.f ====
hw/ray_types_pkg.sv
hw/fp_pipe_pkg.sv
hw/delay_line.sv
hw/fp_mult.sv
hw/fp_add.sv
hw/prime_calc.sv
hw/ray_transform.sv
sim/ray_transform_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module ray_transform_tb -o ray_transform_sim

sim_out=$(./obj_dir/ray_transform_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "All tests passed!"; then
  exit 0
else
  exit 1
fi

// ==== sim/ray_transform_tb.sv ====
// Table-driven testbench for ray_transform with default core latencies
// Table values are exact under truncation; vectors are written x, y, z
`default_nettype none
`timescale 1ns/10ps

module ray_transform_tb;

  localparam int MULT_LAT       = fp_pipe_pkg::MULT_LAT_DEF;
  localparam int ADD_LAT        = fp_pipe_pkg::ADD_LAT_DEF;
  localparam int PRIME_LAT      = MULT_LAT + 2 * ADD_LAT;
  localparam int NUM_CASES      = 6;
  localparam int RST_CYCLES     = 10;
  localparam int TIMEOUT_CYCLES = NUM_CASES * (PRIME_LAT + 40);

  typedef struct packed {
    logic [8*10-1:0]      name;
    ray_types_pkg::vec3_t m1;
    ray_types_pkg::vec3_t m2;
    ray_types_pkg::vec3_t m3;
    ray_types_pkg::vec3_t t;
    ray_types_pkg::vec3_t origin;
    ray_types_pkg::vec3_t dir;
    ray_types_pkg::vec3_t exp_origin;
    ray_types_pkg::vec3_t exp_dir;
    logic [3:0]           ack_dly;
  } case_t;

  function automatic ray_types_pkg::vec3_t xyz(ray_types_pkg::float_t x,
                                               ray_types_pkg::float_t y,
                                               ray_types_pkg::float_t z);
    return {z, y, x};
  endfunction

  // name, m1, m2, m3, t, origin, dir, expected origin, expected dir, ack delay
  localparam case_t CASES [NUM_CASES] = '{
    // Identity, origin (1,2,3), dir (0.5,-1,4)
    '{"identity  ", xyz(32'h3f800000, 32'h0, 32'h0), xyz(32'h0, 32'h3f800000, 32'h0),
      xyz(32'h0, 32'h0, 32'h3f800000), xyz(32'h0, 32'h0, 32'h0),
      xyz(32'h3f800000, 32'h40000000, 32'h40400000), xyz(32'h3f000000, 32'hbf800000, 32'h40800000),
      xyz(32'h3f800000, 32'h40000000, 32'h40400000), xyz(32'h3f000000, 32'hbf800000, 32'h40800000),
      4'd0},
    // t = (10,-2,0.5) gives origin (11,0,3.5)
    '{"translate ", xyz(32'h3f800000, 32'h0, 32'h0), xyz(32'h0, 32'h3f800000, 32'h0),
      xyz(32'h0, 32'h0, 32'h3f800000), xyz(32'h41200000, 32'hc0000000, 32'h3f000000),
      xyz(32'h3f800000, 32'h40000000, 32'h40400000), xyz(32'h3f000000, 32'hbf800000, 32'h40800000),
      xyz(32'h41300000, 32'h0, 32'h40600000), xyz(32'h3f000000, 32'hbf800000, 32'h40800000),
      4'd2},
    // Rows (1,2,-1) (-2,0.5,3) (1.5,-1,2), y lane cancels to +0
    '{"general   ", xyz(32'h3f800000, 32'h40000000, 32'hbf800000),
      xyz(32'hc0000000, 32'h3f000000, 32'h40400000), xyz(32'h3fc00000, 32'hbf800000, 32'h40000000),
      xyz(32'h3f800000, 32'hc1080000, 32'h3f000000),
      xyz(32'h40000000, 32'h3f800000, 32'h40800000), xyz(32'h3f800000, 32'h40000000, 32'hc0400000),
      xyz(32'h3f800000, 32'h0, 32'h41280000), xyz(32'h41000000, 32'hc1200000, 32'hc0d00000),
      4'd4},
    // Zero entries in the matrix and the ray
    '{"zero_terms", xyz(32'h0, 32'h40400000, 32'h0), xyz(32'h40000000, 32'h0, 32'hbf800000),
      xyz(32'h0, 32'h0, 32'h0), xyz(32'h0, 32'h3f800000, 32'h40000000),
      xyz(32'h40a00000, 32'h0, 32'h40000000), xyz(32'h0, 32'hc0000000, 32'h3f800000),
      xyz(32'h0, 32'h41100000, 32'h40000000), xyz(32'hc0c00000, 32'hbf800000, 32'h0),
      4'd1},
    // General matrix again, long out_ack delay
    '{"back_press", xyz(32'h3f800000, 32'h40000000, 32'hbf800000),
      xyz(32'hc0000000, 32'h3f000000, 32'h40400000), xyz(32'h3fc00000, 32'hbf800000, 32'h40000000),
      xyz(32'h40000000, 32'h3f800000, 32'hbf800000),
      xyz(32'hbf800000, 32'h40000000, 32'h3f000000), xyz(32'h3f000000, 32'h3f000000, 32'h3f800000),
      xyz(32'h40900000, 32'h40b00000, 32'hc0600000), xyz(32'h3f000000, 32'h40100000, 32'h40100000),
      4'd6},
    // Diagonal (2,3,-0.5) with t = (1,1,1)
    '{"diag_scale", xyz(32'h40000000, 32'h0, 32'h0), xyz(32'h0, 32'h40400000, 32'h0),
      xyz(32'h0, 32'h0, 32'hbf000000), xyz(32'h3f800000, 32'h3f800000, 32'h3f800000),
      xyz(32'h40400000, 32'h40800000, 32'h40c00000), xyz(32'h3f800000, 32'hbf800000, 32'h41000000),
      xyz(32'h40e00000, 32'h41500000, 32'hc0000000), xyz(32'h40000000, 32'hc0400000, 32'hc0800000),
      4'd0}
  };

  logic                 clk;
  logic                 rst;
  ray_types_pkg::vec3_t m1;
  ray_types_pkg::vec3_t m2;
  ray_types_pkg::vec3_t m3;
  ray_types_pkg::vec3_t t;
  ray_types_pkg::vec3_t in_origin;
  ray_types_pkg::vec3_t in_dir;
  logic                 in_req;
  logic                 in_ack;
  ray_types_pkg::vec3_t out_origin;
  ray_types_pkg::vec3_t out_dir;
  logic                 out_req;
  logic                 out_ack;
  int                   value_errors;
  int                   protocol_errors;
  int                   cycles;

  ray_transform #(
    .MULT_LAT (MULT_LAT),
    .ADD_LAT  (ADD_LAT)
  ) ray_transform_inst (
    .clk, .rst, .m1, .m2, .m3, .t,
    .in_origin, .in_dir, .in_req, .in_ack,
    .out_origin, .out_dir, .out_req, .out_ack
  );

  always #2 clk = ~clk;

  // Run limit counts only cycles after reset
  always @(posedge clk) begin
    if (!rst) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("ERROR: timeout after %0d cycles, a handshake never completed", cycles);
        $display("Test failures found");
        $finish;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic present_ray(input case_t c);
    m1        = c.m1;
    m2        = c.m2;
    m3        = c.m3;
    t         = c.t;
    in_origin = c.origin;
    in_dir    = c.dir;
    in_req    = 1'b1;
  endtask

  task automatic complete_ray();
    while (in_ack !== 1'b1) next_cycle();
    in_req = 1'b0;
    while (in_ack !== 1'b0) next_cycle();
  endtask

  task automatic check_vec(input case_t c, input string label,
                           input ray_types_pkg::vec3_t expected,
                           input ray_types_pkg::vec3_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %0s %0s: expected %h actual %h", c.name, label, expected, actual);
    end
  endtask

  task automatic collect_result(input int idx, input int extra);
    case_t                c;
    ray_types_pkg::vec3_t held_origin;
    ray_types_pkg::vec3_t held_dir;
    c = CASES[idx];
    while (out_req !== 1'b1) next_cycle();
    held_origin = out_origin;
    held_dir    = out_dir;
    // Next ray already requests while the result is withheld
    if (idx + 1 < NUM_CASES) begin
      present_ray(CASES[idx + 1]);
    end
    // Result must hold while out_ack is withheld
    repeat (int'(c.ack_dly) + extra) begin
      next_cycle();
      if (out_req !== 1'b1 || in_ack !== 1'b0) begin
        protocol_errors++;
        $display("ERROR: %0s out_req dropped or in_ack rose before out_ack", c.name);
      end
      if (out_origin !== held_origin || out_dir !== held_dir) begin
        protocol_errors++;
        $display("ERROR: %0s result changed while out_req was high", c.name);
      end
    end
    check_vec(c, "origin", c.exp_origin, out_origin);
    check_vec(c, "dir", c.exp_dir, out_dir);
    out_ack = 1'b1;
    while (out_req !== 1'b0) next_cycle();
    out_ack = 1'b0;
  endtask

  initial begin
    int extra;
    clk             = 1'b0;
    rst             = 1'b1;
    m1              = '0;
    m2              = '0;
    m3              = '0;
    t               = '0;
    in_origin       = '0;
    in_dir          = '0;
    in_req          = 1'b0;
    out_ack         = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    cycles          = 0;
    void'($urandom(32'he2b82ccd));
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();
    if (in_ack !== 1'b0 || out_req !== 1'b0) begin
      protocol_errors++;
      $display("ERROR: in_ack or out_req is not low after reset");
    end
    next_cycle();
    present_ray(CASES[0]);
    // Rays go back to back, one result per case
    for (int i = 0; i < NUM_CASES; i++) begin
      extra = int'($urandom % 8);
      complete_ray();
      collect_result(i, extra);
    end
    $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/ray_transform.sv ====
// Ray transform top: origin' = M*origin + t, dir' = M*dir
// M and t must stay steady while a ray is in flight
// One ray at a time; both sides use four-phase req/ack
`default_nettype none
`timescale 1ns/10ps

module ray_transform #(
  parameter int MULT_LAT = fp_pipe_pkg::MULT_LAT_DEF,
  parameter int ADD_LAT  = fp_pipe_pkg::ADD_LAT_DEF
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire ray_types_pkg::vec3_t m1,
  input  wire ray_types_pkg::vec3_t m2,
  input  wire ray_types_pkg::vec3_t m3,
  input  wire ray_types_pkg::vec3_t t,
  input  wire ray_types_pkg::vec3_t in_origin,
  input  wire ray_types_pkg::vec3_t in_dir,
  input  wire logic                 in_req,
  output logic                      in_ack,
  output ray_types_pkg::vec3_t      out_origin,
  output ray_types_pkg::vec3_t      out_dir,
  output logic                      out_req,
  input  wire logic                 out_ack
);

  localparam int PRIME_LAT = MULT_LAT + 2 * ADD_LAT;
  localparam int FW        = ray_types_pkg::FLOAT_W;

  fp_pipe_pkg::seq_state_t state;

  ray_types_pkg::vec3_t  ray_origin_q;
  ray_types_pkg::vec3_t  ray_dir_q;
  logic [1:0]            issue_row;
  logic                  issue_valid;
  ray_types_pkg::vec3_t  row_m;
  ray_types_pkg::float_t row_t;
  ray_types_pkg::float_t originp;
  ray_types_pkg::float_t dirp;
  logic                  ret_valid;
  logic [1:0]            ret_row;
  logic [1:0]            ret_lane;

  // Row 0 is Z, row 1 is Y, row 2 is X
  always_comb begin
    case (issue_row)
      2'd0: begin
        row_m = m3;
        row_t = ray_types_pkg::vec_z(t);
      end
      2'd1: begin
        row_m = m2;
        row_t = ray_types_pkg::vec_y(t);
      end
      default: begin
        row_m = m1;
        row_t = ray_types_pkg::vec_x(t);
      end
    endcase
  end

  assign issue_valid = (state == fp_pipe_pkg::ISSUE);

  prime_calc #(
    .MULT_LAT (MULT_LAT),
    .ADD_LAT  (ADD_LAT)
  ) prime_calc_inst (
    .clk,
    .rst,
    .ray_origin (ray_origin_q),
    .ray_dir    (ray_dir_q),
    .mk1        (ray_types_pkg::vec_x(row_m)),
    .mk2        (ray_types_pkg::vec_y(row_m)),
    .mk3        (ray_types_pkg::vec_z(row_m)),
    .tk         (row_t),
    .originp,
    .dirp
  );

  // Tags ride alongside the datapath
  delay_line #(.LAT(PRIME_LAT), .WIDTH(1)) valid_tag (
    .clk, .rst, .data_in(issue_valid), .data_out(ret_valid));
  delay_line #(.LAT(PRIME_LAT), .WIDTH(2)) row_tag (
    .clk, .rst, .data_in(issue_row), .data_out(ret_row));

  assign ret_lane = 2'd2 - ret_row;

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      out_origin[ret_lane*FW +: FW] <= originp;
      out_dir[ret_lane*FW +: FW]    <= dirp;
    end
  end

  // Captured ray held for all three rows
  always_ff @(posedge clk) begin
    if (state == fp_pipe_pkg::IDLE && in_req && !in_ack) begin
      ray_origin_q <= in_origin;
      ray_dir_q    <= in_dir;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= fp_pipe_pkg::IDLE;
      issue_row <= '0;
      in_ack    <= 1'b0;
    end else begin
      if (!in_req) begin
        in_ack <= 1'b0;
      end
      case (state)
        fp_pipe_pkg::IDLE: begin
          // Previous ack must be back low first
          if (in_req && !in_ack) begin
            in_ack    <= 1'b1;
            issue_row <= '0;
            state     <= fp_pipe_pkg::ISSUE;
          end
        end
        fp_pipe_pkg::ISSUE: begin
          issue_row <= issue_row + 2'd1;
          if (issue_row == 2'd2) begin
            state <= fp_pipe_pkg::DRAIN;
          end
        end
        fp_pipe_pkg::DRAIN: begin
          if (ret_valid && ret_row == 2'd2) begin
            state <= fp_pipe_pkg::PRESENT;
          end
        end
        fp_pipe_pkg::PRESENT: begin
          if (out_ack) begin
            state <= fp_pipe_pkg::RELEASE;
          end
        end
        default: begin
          if (!out_ack) begin
            state <= fp_pipe_pkg::IDLE;
          end
        end
      endcase
    end
  end

  assign out_req = (state == fp_pipe_pkg::PRESENT);

endmodule

`default_nettype wire

// ==== hw/prime_calc.sv ====
// One matrix row applied to a ray, latency MULT_LAT + 2*ADD_LAT
// Takes a new row every cycle; inputs carry no valid
`default_nettype none
`timescale 1ns/10ps

module prime_calc #(
  parameter int MULT_LAT = fp_pipe_pkg::MULT_LAT_DEF,
  parameter int ADD_LAT  = fp_pipe_pkg::ADD_LAT_DEF
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ray_types_pkg::vec3_t  ray_origin,
  input  wire ray_types_pkg::vec3_t  ray_dir,
  input  wire ray_types_pkg::float_t mk1,
  input  wire ray_types_pkg::float_t mk2,
  input  wire ray_types_pkg::float_t mk3,
  input  wire ray_types_pkg::float_t tk,
  output ray_types_pkg::float_t      originp,
  output ray_types_pkg::float_t      dirp
);

  ray_types_pkg::float_t prod_o1, prod_o2, prod_o3;
  ray_types_pkg::float_t prod_d1, prod_d2, prod_d3;
  ray_types_pkg::float_t t_dly;
  ray_types_pkg::float_t prod_d3_dly;
  ray_types_pkg::float_t sum_o12, sum_o3t;
  ray_types_pkg::float_t sum_d12;

  // Origin side, m*origin + t
  fp_mult #(.LAT(MULT_LAT)) mult_o1 (
    .clk, .rst, .a(ray_types_pkg::vec_x(ray_origin)), .b(mk1), .result(prod_o1));
  fp_mult #(.LAT(MULT_LAT)) mult_o2 (
    .clk, .rst, .a(ray_types_pkg::vec_y(ray_origin)), .b(mk2), .result(prod_o2));
  fp_mult #(.LAT(MULT_LAT)) mult_o3 (
    .clk, .rst, .a(ray_types_pkg::vec_z(ray_origin)), .b(mk3), .result(prod_o3));

  // Translation waits out the multiplier
  delay_line #(.LAT(MULT_LAT), .WIDTH(ray_types_pkg::FLOAT_W)) t_buf (
    .clk, .rst, .data_in(tk), .data_out(t_dly));

  fp_add #(.LAT(ADD_LAT)) add_o12 (
    .clk, .rst, .a(prod_o1), .b(prod_o2), .result(sum_o12));
  fp_add #(.LAT(ADD_LAT)) add_o3t (
    .clk, .rst, .a(prod_o3), .b(t_dly), .result(sum_o3t));
  fp_add #(.LAT(ADD_LAT)) add_osum (
    .clk, .rst, .a(sum_o12), .b(sum_o3t), .result(originp));

  // Direction side, m*dir only
  fp_mult #(.LAT(MULT_LAT)) mult_d1 (
    .clk, .rst, .a(ray_types_pkg::vec_x(ray_dir)), .b(mk1), .result(prod_d1));
  fp_mult #(.LAT(MULT_LAT)) mult_d2 (
    .clk, .rst, .a(ray_types_pkg::vec_y(ray_dir)), .b(mk2), .result(prod_d2));
  fp_mult #(.LAT(MULT_LAT)) mult_d3 (
    .clk, .rst, .a(ray_types_pkg::vec_z(ray_dir)), .b(mk3), .result(prod_d3));

  fp_add #(.LAT(ADD_LAT)) add_d12 (
    .clk, .rst, .a(prod_d1), .b(prod_d2), .result(sum_d12));

  // Third product lines up with the first sum
  delay_line #(.LAT(ADD_LAT), .WIDTH(ray_types_pkg::FLOAT_W)) d3_buf (
    .clk, .rst, .data_in(prod_d3), .data_out(prod_d3_dly));

  fp_add #(.LAT(ADD_LAT)) add_dsum (
    .clk, .rst, .a(sum_d12), .b(prod_d3_dly), .result(dirp));

endmodule

`default_nettype wire

// ==== hw/fp_add.sv ====
// Single-precision add, normal numbers only, truncating
// Zero or denormal inputs count as zero; exact cancellation gives +0
// Exponent overflow is not detected
`default_nettype none
`timescale 1ns/10ps

module fp_add #(
  parameter int LAT = fp_pipe_pkg::ADD_LAT_DEF
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ray_types_pkg::float_t a,
  input  wire ray_types_pkg::float_t b,
  output ray_types_pkg::float_t      result
);

  localparam int FW = ray_types_pkg::FRAC_W;
  localparam int EW = ray_types_pkg::EXP_W;
  localparam int MW = FW + 1;

  logic                  a_zero;
  logic                  b_zero;
  logic                  a_ge_b;
  ray_types_pkg::float_t hi_op;
  ray_types_pkg::float_t lo_op;
  ray_types_pkg::exp_t   exp_diff;
  ray_types_pkg::mant_t  hi_mant;
  ray_types_pkg::mant_t  lo_mant;
  ray_types_pkg::mant_t  lo_aligned;
  logic [MW:0]           sum;
  logic [4:0]            lz;
  ray_types_pkg::mant_t  norm_mant;
  logic [EW:0]           norm_exp;
  ray_types_pkg::exp_t   carry_exp;
  ray_types_pkg::float_t res_comb;

  assign a_zero = (a[FW +: EW] == '0);
  assign b_zero = (b[FW +: EW] == '0);

  // Magnitude order works on the raw bits for normal numbers
  assign a_ge_b = (a[FW+EW-1:0] >= b[FW+EW-1:0]);
  assign hi_op  = a_ge_b ? a : b;
  assign lo_op  = a_ge_b ? b : a;

  assign exp_diff   = hi_op[FW +: EW] - lo_op[FW +: EW];
  assign hi_mant    = {1'b1, hi_op[FW-1:0]};
  assign lo_mant    = {1'b1, lo_op[FW-1:0]};
  // Bits shifted out are simply lost
  assign lo_aligned = lo_mant >> exp_diff;

  // Unlike signs subtract; hi_op is never smaller so no borrow
  assign sum = (hi_op[FW+EW] ^ lo_op[FW+EW]) ? {1'b0, hi_mant} - {1'b0, lo_aligned}
                                             : {1'b0, hi_mant} + {1'b0, lo_aligned};

  // Leading zeros of the 24-bit sum, highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < MW; i++) begin
      if (sum[i]) begin
        lz = 5'(MW - 1 - i);
      end
    end
  end

  assign norm_mant = sum[MW-1:0] << lz;
  assign norm_exp  = {1'b0, hi_op[FW +: EW]} - {{(EW-4){1'b0}}, lz};
  assign carry_exp = hi_op[FW +: EW] + ray_types_pkg::exp_t'(1);

  always_comb begin
    if (a_zero && b_zero) begin
      res_comb = '0;
    end else if (a_zero) begin
      res_comb = b;
    end else if (b_zero) begin
      res_comb = a;
    end else if (sum[MW]) begin
      // Carry out, shift right by one
      res_comb = {hi_op[FW+EW], carry_exp, sum[MW-1:1]};
    end else if (sum[MW-1:0] == '0) begin
      res_comb = '0;
    end else if (norm_exp[EW] || (norm_exp == '0)) begin
      // Renormalized below the normal range
      res_comb = '0;
    end else begin
      res_comb = {hi_op[FW+EW], norm_exp[EW-1:0], norm_mant[FW-1:0]};
    end
  end

  delay_line #(
    .LAT   (LAT),
    .WIDTH (ray_types_pkg::FLOAT_W)
  ) result_pipe (
    .clk,
    .rst,
    .data_in  (res_comb),
    .data_out (result)
  );

endmodule

`default_nettype wire

// ==== hw/fp_mult.sv ====
// Single-precision multiply, normal numbers only, truncating
// Zero or denormal inputs give +0; exponent overflow is not detected
`default_nettype none
`timescale 1ns/10ps

module fp_mult #(
  parameter int LAT = fp_pipe_pkg::MULT_LAT_DEF
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ray_types_pkg::float_t a,
  input  wire ray_types_pkg::float_t b,
  output ray_types_pkg::float_t      result
);

  localparam int FW = ray_types_pkg::FRAC_W;
  localparam int EW = ray_types_pkg::EXP_W;
  localparam int MW = FW + 1;

  ray_types_pkg::exp_t   exp_a;
  ray_types_pkg::exp_t   exp_b;
  ray_types_pkg::mant_t  mant_a;
  ray_types_pkg::mant_t  mant_b;
  logic [2*MW-1:0]       prod;
  logic [FW-1:0]         frac;
  logic [EW+1:0]         exp_sum;
  logic                  sign;
  logic                  flush;
  ray_types_pkg::float_t res_comb;

  assign exp_a  = a[FW +: EW];
  assign exp_b  = b[FW +: EW];
  assign mant_a = {1'b1, a[FW-1:0]};
  assign mant_b = {1'b1, b[FW-1:0]};
  assign sign   = a[FW+EW] ^ b[FW+EW];

  // Product of two 1.x mantissas lies in [1, 4)
  assign prod = mant_a * mant_b;

  // Normalize by one bit when the product reached 2.0
  assign frac = prod[2*MW-1] ? prod[2*MW-2 -: FW] : prod[2*MW-3 -: FW];

  assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} + {{(EW+1){1'b0}}, prod[2*MW-1]}
                 - (EW+2)'(ray_types_pkg::EXP_BIAS);

  // Zero inputs, and results below the normal range, go to +0
  assign flush = (exp_a == '0) || (exp_b == '0) || exp_sum[EW+1] || (exp_sum == '0);

  always_comb begin
    if (flush) begin
      res_comb = '0;
    end else begin
      res_comb = {sign, exp_sum[EW-1:0], frac};
    end
  end

  delay_line #(
    .LAT   (LAT),
    .WIDTH (ray_types_pkg::FLOAT_W)
  ) result_pipe (
    .clk,
    .rst,
    .data_in  (res_comb),
    .data_out (result)
  );

endmodule

`default_nettype wire

// ==== hw/delay_line.sv ====
// Fixed delay of LAT cycles, LAT must be at least 1
`default_nettype none
`timescale 1ns/10ps

module delay_line #(
  parameter int LAT   = 1,
  parameter int WIDTH = 32
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [WIDTH-1:0] data_in,
  output logic      [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stage [LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LAT; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= data_in;
      for (int i = 1; i < LAT; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign data_out = stage[LAT-1];

endmodule

`default_nettype wire

// ==== hw/fp_pipe_pkg.sv ====
// Default core latencies and the row sequencer states
// Latencies must stay at one or more cycles
`default_nettype none

package fp_pipe_pkg;

  localparam int MULT_LAT_DEF = 3;
  localparam int ADD_LAT_DEF  = 4;

  // Ray capture, row issue, wait for results, result handshake
  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    DRAIN,
    PRESENT,
    RELEASE
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/ray_types_pkg.sv ====
// Field widths for IEEE-754 single floats and packed xyz vectors
// Vectors pack z, y, x with x in the low word
`default_nettype none

package ray_types_pkg;

  localparam int FLOAT_W  = 32;
  localparam int EXP_W    = 8;
  localparam int FRAC_W   = 23;
  localparam int EXP_BIAS = 127;

  typedef logic [FLOAT_W-1:0]   float_t;
  typedef logic [EXP_W-1:0]     exp_t;
  // Mantissa including the hidden bit
  typedef logic [FRAC_W:0]      mant_t;
  typedef logic [3*FLOAT_W-1:0] vec3_t;

  function automatic float_t vec_x(vec3_t v);
    return v[0 +: FLOAT_W];
  endfunction

  function automatic float_t vec_y(vec3_t v);
    return v[FLOAT_W +: FLOAT_W];
  endfunction

  function automatic float_t vec_z(vec3_t v);
    return v[2*FLOAT_W +: FLOAT_W];
  endfunction

endpackage

`default_nettype wire
